// ==== rtl/cache_ctrl.sv ====
module cache_ctrl (
   input  logic                           clk,
   input  logic                           rstn,
   input  cache_pkg::cpu_req_t            cpu_req,
   input  logic                           cpu_req_valid,
   output logic                           cpu_req_ready,
   output cache_pkg::word_t               cpu_rdata,
   output logic                           cpu_resp_valid,
   input  logic                           cpu_resp_ready,
   output cache_pkg::index_t              store_addr,
   output logic [cache_pkg::NUM_WAYS-1:0] way_wr,
   output cache_pkg::line_t               way_wdata,
   input  cache_pkg::lru_t                lru_rdata,
   output logic                           lru_wr,
   output cache_pkg::lru_t                lru_wdata,
   input  logic                           hit,
   input  cache_pkg::way_t                hit_way,
   input  cache_pkg::line_t               hit_line,
   input  cache_pkg::way_t                victim_way,
   input  cache_pkg::line_t               victim_line,
   output logic                           miss_req,
   output cache_pkg::miss_cmd_t           miss_cmd,
   input  logic                           miss_ack,
   input  cache_pkg::line_data_t          fill_data,
   output cache_pkg::tag_t                lookup_tag
);

   typedef enum logic [2:0] {
      S_SWEEP,
      S_IDLE,
      S_READ,
      S_LOOKUP,
      S_RESP,
      S_MISS,
      S_FILL
   } state_t;

   state_t                      state;
   cache_pkg::index_t           sweep_idx;
   cache_pkg::cpu_req_t         req_q;
   cache_pkg::way_t             victim_q;
   cache_pkg::index_t           req_index;
   logic [cache_pkg::OFS_W-1:0] req_ofs;
   cache_pkg::line_data_t       merged;

   //////////////////////////////////////////////////
   // address split: tag | index | word | byte
   //////////////////////////////////////////////////

   assign lookup_tag = req_q.addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
   assign req_index  = req_q.addr[cache_pkg::OFS_W+2 +: cache_pkg::INDEX_W];
   assign req_ofs    = req_q.addr[2 +: cache_pkg::OFS_W]; // above the byte offset

   // write hits fold the strobed bytes into the hit line
   assign merged = req_q.write ?
                   cache_pkg::merge_word(hit_line.data, req_ofs, req_q.wdata, req_q.wstrb) :
                   hit_line.data;

   assign cpu_req_ready = (state == S_IDLE);

   always_ff @(posedge clk) begin
      if (rstn) begin
         state          <= S_SWEEP;
         sweep_idx      <= '0;
         store_addr     <= '0;
         way_wr         <= '0;
         lru_wr         <= 1'b0;
         cpu_resp_valid <= 1'b0;
         miss_req       <= 1'b0;
      end else begin
         way_wr <= '0;   // write strobes are single cycle
         lru_wr <= 1'b0;
         case (state)
            S_SWEEP: begin
               // one set per cycle, all ways invalid
               store_addr <= sweep_idx;
               way_wr     <= '1;
               way_wdata  <= '0;
               lru_wr     <= 1'b1;
               lru_wdata  <= cache_pkg::LRU_RESET;
               sweep_idx  <= sweep_idx + 1'b1;
               if (sweep_idx == cache_pkg::index_t'(cache_pkg::NUM_SETS - 1)) state <= S_IDLE;
            end
            S_IDLE: begin
               if (cpu_req_valid) begin
                  req_q      <= cpu_req;
                  store_addr <= cpu_req.addr[cache_pkg::OFS_W+2 +: cache_pkg::INDEX_W];
                  state      <= S_READ;
               end
            end
            S_READ: begin
               state <= S_LOOKUP; // arrays read this cycle
            end
            S_LOOKUP: begin
               if (hit) begin
                  cpu_rdata       <= merged[req_ofs];
                  cpu_resp_valid  <= 1'b1;
                  way_wr[hit_way] <= req_q.write;
                  way_wdata       <= '{valid: 1'b1, dirty: 1'b1, tag: lookup_tag, data: merged};
                  lru_wr          <= 1'b1;
                  lru_wdata       <= cache_pkg::lru_touch(lru_rdata, hit_way);
                  state           <= S_RESP;
               end else begin
                  miss_req <= 1'b1;
                  miss_cmd <= '{victim: victim_line, tag: lookup_tag, index: req_index};
                  victim_q <= victim_way;
                  state    <= S_MISS;
               end
            end
            S_RESP: begin
               if (cpu_resp_ready) begin
                  cpu_resp_valid <= 1'b0;
                  state          <= S_IDLE;
               end
            end
            S_MISS: begin
               if (miss_ack) begin
                  miss_req         <= 1'b0;
                  way_wr[victim_q] <= 1'b1; // fetched line goes in clean
                  way_wdata        <= '{valid: 1'b1, dirty: 1'b0, tag: lookup_tag,
                                        data: fill_data};
                  state            <= S_FILL;
               end
            end
            S_FILL: begin
               // wait for ack release, then re-read so the lookup hits
               if (!miss_ack) state <= S_READ;
            end
            default: state <= S_SWEEP;
         endcase
      end
   end

endmodule

// ==== rtl/cache_pkg.sv ====
package cache_pkg;

   //////////////////////////////////////////////////
   // geometry
   //////////////////////////////////////////////////

   localparam int ADDR_W         = 32;
   localparam int WORD_W         = 32;
   localparam int STRB_W         = 4;
   localparam int WORDS_PER_LINE = 4;
   localparam int OFS_W          = 2;
   localparam int NUM_SETS       = 16;
   localparam int INDEX_W        = 4;
   localparam int TAG_W          = 24; // addr minus index, word and byte offset
   localparam int NUM_WAYS       = 4;
   localparam int WAY_W          = 2;

   typedef logic [WORD_W-1:0]  word_t;
   typedef logic [TAG_W-1:0]   tag_t;
   typedef logic [INDEX_W-1:0] index_t;
   typedef logic [WAY_W-1:0]   way_t;

   typedef word_t [WORDS_PER_LINE-1:0] line_data_t;

   typedef struct packed {
      logic       valid;
      logic       dirty;
      tag_t       tag;
      line_data_t data;
   } line_t;

   // element 0 is the most recently used way, element 3 the victim
   typedef way_t [NUM_WAYS-1:0] lru_t;

   localparam lru_t LRU_RESET = {2'd3, 2'd2, 2'd1, 2'd0};

   typedef struct packed {
      logic [ADDR_W-1:0] addr;  // byte address
      logic              write;
      word_t             wdata;
      logic [STRB_W-1:0] wstrb;
   } cpu_req_t;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;  // byte address of the word, low bits zero
      logic              write;
      word_t             wdata;
   } mem_req_t;

   typedef struct packed {
      line_t  victim;
      tag_t   tag;    // line to fetch
      index_t index;
   } miss_cmd_t;

   //////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////

   // move way to the front, rest keeps its order
   function automatic lru_t lru_touch(input lru_t lru, input way_t way);
      lru_t res;
      logic found;
      res   = lru;
      found = 1'b0;
      res[0] = way;
      for (int i = 1; i < NUM_WAYS; i++) begin
         if (lru[i-1] == way) found = 1'b1;
         if (!found) res[i] = lru[i-1]; // shift down until the old slot
      end
      return res;
   endfunction

   function automatic line_data_t merge_word(input line_data_t data,
                                             input logic [OFS_W-1:0] ofs,
                                             input word_t wdata,
                                             input logic [STRB_W-1:0] wstrb);
      line_data_t res;
      res = data;
      for (int b = 0; b < STRB_W; b++) begin
         if (wstrb[b]) res[ofs][8*b +: 8] = wdata[8*b +: 8];
      end
      return res;
   endfunction

endpackage

// ==== rtl/cache_top.sv ====
module cache_top (
   input  logic                clk,
   input  logic                rstn,
   input  cache_pkg::cpu_req_t cpu_req,
   input  logic                cpu_req_valid,
   output logic                cpu_req_ready,
   output cache_pkg::word_t    cpu_rdata,
   output logic                cpu_resp_valid,
   input  logic                cpu_resp_ready,
   output cache_pkg::mem_req_t mem_req,
   output logic                mem_req_valid,
   input  logic                mem_req_ready,
   input  cache_pkg::word_t    mem_rdata,
   input  logic                mem_resp_valid,
   output logic                mem_resp_ready
);

   cache_pkg::index_t                         store_addr;
   logic [cache_pkg::NUM_WAYS-1:0]            way_wr;
   cache_pkg::line_t                          way_wdata;
   cache_pkg::line_t [cache_pkg::NUM_WAYS-1:0] way_rdata;
   cache_pkg::lru_t                           lru_rdata;
   logic                                      lru_wr;
   cache_pkg::lru_t                           lru_wdata;
   logic                                      hit;
   cache_pkg::way_t                           hit_way;
   cache_pkg::line_t                          hit_line;
   cache_pkg::way_t                           victim_way;
   cache_pkg::line_t                          victim_line;
   logic                                      miss_req;
   cache_pkg::miss_cmd_t                      miss_cmd;
   logic                                      miss_ack;
   cache_pkg::line_data_t                     fill_data;
   cache_pkg::tag_t                           lookup_tag;

   cache_ctrl u_ctrl (.*);

   way_lookup u_lookup (
      .lines(way_rdata), .lru(lru_rdata), .tag(lookup_tag), .hit, .hit_way, .hit_line,
      .victim_way, .victim_line
   );

   refill_engine u_refill (.*);

   //////////////////////////////////////////////////
   // set arrays, one per way plus the lru table
   //////////////////////////////////////////////////

   set_store #(.entry_t(cache_pkg::line_t)) u_way0 (
      .clk, .rstn, .addr(store_addr), .wr(way_wr[0]), .wdata(way_wdata), .rdata(way_rdata[0])
   );
   set_store #(.entry_t(cache_pkg::line_t)) u_way1 (
      .clk, .rstn, .addr(store_addr), .wr(way_wr[1]), .wdata(way_wdata), .rdata(way_rdata[1])
   );
   set_store #(.entry_t(cache_pkg::line_t)) u_way2 (
      .clk, .rstn, .addr(store_addr), .wr(way_wr[2]), .wdata(way_wdata), .rdata(way_rdata[2])
   );
   set_store #(.entry_t(cache_pkg::line_t)) u_way3 (
      .clk, .rstn, .addr(store_addr), .wr(way_wr[3]), .wdata(way_wdata), .rdata(way_rdata[3])
   );

   set_store #(.entry_t(cache_pkg::lru_t)) u_lru (
      .clk, .rstn, .addr(store_addr), .wr(lru_wr), .wdata(lru_wdata), .rdata(lru_rdata)
   );

endmodule

// ==== rtl/refill_engine.sv ====
module refill_engine (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  miss_req,
   input  cache_pkg::miss_cmd_t  miss_cmd,
   output logic                  miss_ack,
   output cache_pkg::line_data_t fill_data,
   output cache_pkg::mem_req_t   mem_req,
   output logic                  mem_req_valid,
   input  logic                  mem_req_ready,
   input  cache_pkg::word_t      mem_rdata,
   input  logic                  mem_resp_valid,
   output logic                  mem_resp_ready
);

   typedef enum logic [1:0] {
      R_IDLE,
      R_WRITE,
      R_READ,
      R_DONE
   } rstate_t;

   rstate_t                     state;
   logic [cache_pkg::OFS_W-1:0] word_cnt;
   logic [cache_pkg::OFS_W-1:0] next_cnt;
   logic                        last_beat;
   cache_pkg::line_data_t       line_buf;

   // one memory beat, addressed by tag, index and word offset
   function automatic cache_pkg::mem_req_t beat(input logic wr,
                                                input cache_pkg::tag_t tag,
                                                input cache_pkg::index_t index,
                                                input logic [cache_pkg::OFS_W-1:0] ofs,
                                                input cache_pkg::word_t wdata);
      cache_pkg::mem_req_t req;
      req.addr  = {tag, index, ofs, 2'b00};
      req.write = wr;
      req.wdata = wdata;
      return req;
   endfunction

   assign next_cnt  = word_cnt + 1'b1;
   assign last_beat = &word_cnt; // line length is a power of two
   assign fill_data = line_buf;

   always_ff @(posedge clk) begin
      if (rstn) begin
         state          <= R_IDLE;
         word_cnt       <= '0;
         miss_ack       <= 1'b0;
         mem_req_valid  <= 1'b0;
         mem_resp_ready <= 1'b0;
      end else begin
         case (state)
            R_IDLE: begin
               if (miss_req) begin
                  word_cnt      <= '0;
                  mem_req_valid <= 1'b1;
                  if (miss_cmd.victim.valid && miss_cmd.victim.dirty) begin
                     mem_req <= beat(1'b1, miss_cmd.victim.tag, miss_cmd.index, '0,
                                     miss_cmd.victim.data[0]);
                     state   <= R_WRITE;
                  end else begin
                     mem_req <= beat(1'b0, miss_cmd.tag, miss_cmd.index, '0, '0);
                     state   <= R_READ;
                  end
               end
            end
            R_WRITE, R_READ: begin
               // request phase, then response phase of the same beat
               if (mem_req_valid && mem_req_ready) begin
                  mem_req_valid  <= 1'b0;
                  mem_resp_ready <= 1'b1;
               end
               if (mem_resp_valid && mem_resp_ready) begin
                  mem_resp_ready <= 1'b0;
                  word_cnt       <= next_cnt;
                  if (state == R_READ) line_buf[word_cnt] <= mem_rdata;
                  if (state == R_WRITE && !last_beat) begin
                     mem_req_valid <= 1'b1;
                     mem_req       <= beat(1'b1, miss_cmd.victim.tag, miss_cmd.index, next_cnt,
                                           miss_cmd.victim.data[next_cnt]);
                  end else if (state == R_WRITE || !last_beat) begin
                     // next fetch beat, counter wraps to 0 after write back
                     mem_req_valid <= 1'b1;
                     mem_req       <= beat(1'b0, miss_cmd.tag, miss_cmd.index, next_cnt, '0);
                     state         <= R_READ;
                  end else begin
                     miss_ack <= 1'b1; // line complete
                     state    <= R_DONE;
                  end
               end
            end
            R_DONE: begin
               if (!miss_req) begin
                  miss_ack <= 1'b0;
                  state    <= R_IDLE;
               end
            end
            default: state <= R_IDLE;
         endcase
      end
   end

endmodule

// ==== rtl/set_store.sv ====
module set_store #(
   parameter type entry_t = logic
) (
   input  logic              clk,
   input  logic              rstn,
   input  cache_pkg::index_t addr,
   input  logic              wr,
   input  entry_t            wdata,
   output entry_t            rdata
);

   entry_t mem [cache_pkg::NUM_SETS];

   always_ff @(posedge clk) begin
      if (wr) mem[addr] <= wdata;
   end

   // read returns old contents on a same-cycle write
   always_ff @(posedge clk) begin
      if (rstn) begin
         rdata <= '0;
      end else begin
         rdata <= mem[addr];
      end
   end

endmodule

// ==== rtl/way_lookup.sv ====
module way_lookup (
   input  cache_pkg::line_t [cache_pkg::NUM_WAYS-1:0] lines,
   input  cache_pkg::lru_t                            lru,
   input  cache_pkg::tag_t                            tag,
   output logic                                       hit,
   output cache_pkg::way_t                            hit_way,
   output cache_pkg::line_t                           hit_line,
   output cache_pkg::way_t                            victim_way,
   output cache_pkg::line_t                           victim_line
);

   // tag compare over all valid ways
   always_comb begin
      hit     = 1'b0;
      hit_way = '0;
      for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
         if (lines[w].valid && (lines[w].tag == tag)) begin
            hit     = 1'b1;
            hit_way = cache_pkg::way_t'(w);
         end
      end
   end

   assign hit_line = lines[hit_way];

   // victim sits at the back of the lru order
   assign victim_way  = lru[cache_pkg::NUM_WAYS-1];
   assign victim_line = lines[victim_way];

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_cache -f tb.f -o sim_cache
status=$?
if [ $status -ne 0 ]; then
   echo "build failed"
   exit $status
fi

./obj_dir/sim_cache
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed"
fi
exit $status

// ==== tb.f ====
rtl/cache_pkg.sv
rtl/set_store.sv
rtl/way_lookup.sv
rtl/cache_ctrl.sv
rtl/refill_engine.sv
rtl/cache_top.sv
tests/mem_model.sv
tests/tb_cache.sv

// ==== tests/mem_model.sv ====
module mem_model (
   input  logic                clk,
   input  logic                rstn,
   input  cache_pkg::mem_req_t mem_req,
   input  logic                mem_req_valid,
   output logic                mem_req_ready,
   output cache_pkg::word_t    mem_rdata,
   output logic                mem_resp_valid,
   input  logic                mem_resp_ready
);
   timeunit 1ns;
   timeprecision 1ps;

   typedef enum logic [1:0] {M_IDLE, M_REQ, M_DLY, M_RESP} mstate_t;

   mstate_t                state;
   logic [31:0]            seed;
   logic [31:0]            nxt;
   logic [1:0]             cnt;
   cache_pkg::word_t       mem [logic [31:0]]; // written words only
   int                     rd_beats [logic [31:0]];
   int                     wr_beats [logic [31:0]];
   int                     rd_total;
   int                     wr_total;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic cache_pkg::word_t read_word(input logic [31:0] a);
      if (mem.exists(a)) return mem[a];
      return a ^ 32'h5a5a0000; // untouched words follow the pattern
   endfunction

   always @(posedge clk) begin
      if (rstn) begin
         state          <= M_IDLE;
         seed           <= 32'h263e;
         mem_req_ready  <= 1'b0;
         mem_resp_valid <= 1'b0;
         mem_rdata      <= '0;
         rd_total       <= 0;
         wr_total       <= 0;
      end else begin
         case (state)
            M_IDLE: if (mem_req_valid) begin
               nxt = xorshift(seed);
               seed  <= nxt;
               cnt   <= nxt[1:0];     // 0 to 3 cycles
               state <= M_REQ;
            end
            M_REQ: begin
               if (mem_req_ready && mem_req_valid) begin
                  mem_req_ready <= 1'b0;
                  if (mem_req.write) begin
                     mem[mem_req.addr] = mem_req.wdata;
                     wr_beats[mem_req.addr] = wr_beats.exists(mem_req.addr) ?
                                              wr_beats[mem_req.addr] + 1 : 1;
                     wr_total <= wr_total + 1;
                  end else begin
                     rd_beats[mem_req.addr] = rd_beats.exists(mem_req.addr) ?
                                              rd_beats[mem_req.addr] + 1 : 1;
                     rd_total <= rd_total + 1;
                  end
                  mem_rdata <= mem_req.write ? '0 : read_word(mem_req.addr);
                  nxt = xorshift(seed);
                  seed  <= nxt;
                  cnt   <= nxt[1:0];
                  state <= M_DLY;
               end else if (cnt == 2'd0) begin
                  mem_req_ready <= 1'b1;
               end else begin
                  cnt <= cnt - 2'd1;
               end
            end
            M_DLY: begin
               if (cnt == 2'd0) begin
                  mem_resp_valid <= 1'b1;
                  state          <= M_RESP;
               end else begin
                  cnt <= cnt - 2'd1;
               end
            end
            M_RESP: if (mem_resp_valid && mem_resp_ready) begin
               mem_resp_valid <= 1'b0;
               state          <= M_IDLE;
            end
            default: state <= M_IDLE;
         endcase
      end
   end

endmodule

// ==== tests/tb_cache.sv ====
module tb_cache;
   timeunit 1ns;
   timeprecision 1ps;

   logic                clk;
   logic                rstn;
   cache_pkg::cpu_req_t cpu_req;
   logic                cpu_req_valid;
   logic                cpu_req_ready;
   cache_pkg::word_t    cpu_rdata;
   logic                cpu_resp_valid;
   logic                cpu_resp_ready;
   cache_pkg::mem_req_t mem_req;
   logic                mem_req_valid;
   logic                mem_req_ready;
   cache_pkg::word_t    mem_rdata;
   logic                mem_resp_valid;
   logic                mem_resp_ready;

   cache_pkg::word_t    shadow [logic [31:0]]; // expected contents after writes
   int                  cycles;
   int                  rd0;
   int                  wr0;
   int                  lat;

   cache_top UUT (.*);
   mem_model u_mem (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= 4000) begin
         $display("timeout, DUT stopped answering after %0d cycles", cycles);
         $display("Test failed");
         $fatal(1);
      end
   end

   ////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////

   function automatic logic [31:0] mk_addr(input logic [23:0] tag, input logic [3:0] idx,
                                           input logic [1:0] ofs);
      return {tag, idx, ofs, 2'b00};
   endfunction

   function automatic cache_pkg::word_t expect_word(input logic [31:0] a);
      return shadow.exists(a) ? shadow[a] : (a ^ 32'h5a5a0000);
   endfunction

   function automatic cache_pkg::word_t strobe_mix(input cache_pkg::word_t old_w,
                                                   input cache_pkg::word_t new_w,
                                                   input logic [3:0] strb);
      logic [31:0] mask;
      mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
      return (new_w & mask) | (old_w & ~mask);
   endfunction

   // beats mem_model logged on the four words of one line
   function automatic int line_beats(input logic [31:0] line_a, input logic wr);
      logic [31:0] wa;
      int          n;
      n = 0;
      for (int w = 0; w < 4; w++) begin
         wa = line_a + 32'(4 * w);
         if (wr && u_mem.wr_beats.exists(wa)) n += u_mem.wr_beats[wa];
         if (!wr && u_mem.rd_beats.exists(wa)) n += u_mem.rd_beats[wa];
      end
      return n;
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got == exp) else begin
         $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   task automatic mark_beats();
      rd0 = u_mem.rd_total;
      wr0 = u_mem.wr_total;
   endtask

   task automatic check_beats(input int drd, input int dwr);
      check_val("read beats", u_mem.rd_total - rd0, drd);
      check_val("write beats", u_mem.wr_total - wr0, dwr);
   endtask

   // one request; hold > 0 keeps cpu_resp_ready low that many cycles
   task automatic access(input logic [31:0] a, input logic wr, input cache_pkg::word_t wd,
                         input logic [3:0] strb, input int hold, output int edges);
      cache_pkg::word_t exp;
      cache_pkg::word_t first;
      exp = wr ? strobe_mix(expect_word(a), wd, strb) : expect_word(a);
      @(posedge clk);
      cpu_req        <= '{addr: a, write: wr, wdata: wd, wstrb: strb};
      cpu_req_valid  <= 1'b1;
      cpu_resp_ready <= (hold == 0);
      do @(posedge clk); while (!cpu_req_ready);
      cpu_req_valid <= 1'b0;
      edges = 0;
      do begin
         @(posedge clk);
         edges++;
      end while (!cpu_resp_valid);
      first = cpu_rdata;
      check_val("cpu_rdata", first, exp);
      for (int i = 0; i < hold; i++) begin
         if (i == hold - 1) cpu_resp_ready <= 1'b1;
         @(posedge clk);
         check_val("cpu_resp_valid", cpu_resp_valid, 1'b1);
         check_val("cpu_rdata held", cpu_rdata, first);
         check_val("cpu_req_ready", cpu_req_ready, 1'b0);
      end
      if (wr) shadow[a] = exp;
   endtask

   ////////////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////////////

   task automatic cold_miss_then_hit();
      mark_beats();
      access(mk_addr(24'h1, 4'h3, 2'd0), 1'b0, '0, '0, 0, lat);
      check_beats(4, 0);
      check_val("line read beats", line_beats(mk_addr(24'h1, 4'h3, 2'd0), 1'b0), 4);
      mark_beats();
      access(mk_addr(24'h1, 4'h3, 2'd2), 1'b0, '0, '0, 0, lat);
      check_beats(0, 0);
      check_val("hit latency", lat, 3); // valid set at edge 2 and sampled high at edge 3
   endtask

   task automatic strobed_write();
      mark_beats();
      access(mk_addr(24'h1, 4'h3, 2'd1), 1'b1, 32'hdeadbeef, 4'b0101, 0, lat);
      access(mk_addr(24'h1, 4'h3, 2'd1), 1'b0, '0, '0, 0, lat);
      check_beats(0, 0);
   endtask

   task automatic dirty_eviction();
      logic [31:0] a;
      logic [31:0] wa;
      a = mk_addr(24'h1, 4'h3, 2'd1);
      for (int t = 2; t <= 4; t++) access(mk_addr(24'(t), 4'h3, 2'd0), 1'b0, '0, '0, 0, lat);
      mark_beats();
      access(mk_addr(24'h5, 4'h3, 2'd0), 1'b0, '0, '0, 0, lat);
      check_beats(4, 4);
      check_val("line write beats", line_beats(mk_addr(24'h1, 4'h3, 2'd0), 1'b1), 4);
      for (int w = 0; w < 4; w++) begin
         wa = mk_addr(24'h1, 4'h3, 2'(w));
         check_val("memory word", u_mem.mem[wa], expect_word(wa));
      end
      mark_beats();
      access(a, 1'b0, '0, '0, 0, lat);
      check_beats(4, 0);
   endtask

   task automatic lru_order();
      for (int t = 10; t <= 13; t++) access(mk_addr(24'(t), 4'h7, 2'd0), 1'b0, '0, '0, 0, lat);
      mark_beats();
      access(mk_addr(24'd10, 4'h7, 2'd3), 1'b0, '0, '0, 0, lat);
      check_beats(0, 0);
      access(mk_addr(24'd14, 4'h7, 2'd0), 1'b0, '0, '0, 0, lat);
      mark_beats();
      access(mk_addr(24'd10, 4'h7, 2'd1), 1'b0, '0, '0, 0, lat);
      check_beats(0, 0);
      access(mk_addr(24'd11, 4'h7, 2'd0), 1'b0, '0, '0, 0, lat);
      check_beats(4, 0);   // B was at the back and got evicted
      check_val("line read beats", line_beats(mk_addr(24'd11, 4'h7, 2'd0), 1'b0), 8);
   endtask

   task automatic resp_backpressure();
      mark_beats();
      access(mk_addr(24'd10, 4'h7, 2'd2), 1'b0, '0, '0, 5, lat);
      check_beats(0, 0);
      access(mk_addr(24'h33, 4'h9, 2'd1), 1'b0, '0, '0, 6, lat);
      check_beats(4, 0);
   endtask

   initial begin
      rstn           = 1'b1;
      cpu_req        = '0;
      cpu_req_valid  = 1'b0;
      cpu_resp_ready = 1'b1;
      cycles         = 0;
      repeat (2) @(posedge clk);
      rstn <= 1'b0;
      cold_miss_then_hit();
      strobed_write();
      dirty_eviction();
      lru_order();
      resp_backpressure();
      $display("Test passed");
      $finish;
   end

endmodule
